// File: hw/heep_io_pkg.sv
// ----------------------------------------------------------
// Shared types and constants for the I/O wrapper
// ----------------------------------------------------------

package heep_io_pkg;

  // Bus fields
  typedef logic [31:0] obi_addr_t;
  typedef logic [31:0] obi_data_t;
  typedef logic [3:0]  obi_be_t;

  // Pad-control register port
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // Byte address to word index
  localparam int unsigned REG_IDX_LSB = 2;
  localparam int unsigned REG_IDX_W   = $bits(reg_addr_t) - REG_IDX_LSB;

  // Select bit position in register data
  localparam int unsigned REG_SEL_BIT = 0;

  // Alternate-function select encoding
  localparam logic PAD_SEL_PERIPH = 1'b0;
  localparam logic PAD_SEL_GPIO   = 1'b1;

endpackage

// File: hw/rst_sync.sv
// ----------------------------------------------------------
// Reset synchronizer, clears at once and releases after
// a chain of flops fills with ones
// ----------------------------------------------------------

`timescale 1ns/1ps

module rst_sync #(
  parameter int unsigned RST_SYNC_STAGES = 2
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_sync_n_o
);

  logic [RST_SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= (sync_q << 1) | RST_SYNC_STAGES'(1);
    end
  end

  assign rst_sync_n_o = sync_q[RST_SYNC_STAGES-1];

endmodule

// File: hw/pad_ctrl_regs.sv
// ----------------------------------------------------------
// Pad control registers, one alternate-function select
// per shared pad behind a word-indexed register port
// ----------------------------------------------------------

`timescale 1ns/1ps

module pad_ctrl_regs
  import heep_io_pkg::*;
#(
  parameter int unsigned NUM_MUX_PADS = 14
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  reg_addr_t               reg_addr_i,
  input  reg_data_t               reg_wdata_i,
  output reg_data_t               reg_rdata_o,
  output logic                    reg_error_o,
  output logic [NUM_MUX_PADS-1:0] pad_sel_o
);

  logic [REG_IDX_W-1:0]    reg_idx;
  logic [NUM_MUX_PADS-1:0] idx_hit;
  logic                    idx_ok;
  logic [NUM_MUX_PADS-1:0] sel_q;

  // Word index, low address bits ignored
  assign reg_idx = reg_addr_i[$bits(reg_addr_t)-1:REG_IDX_LSB];

  for (genvar i = 0; i < NUM_MUX_PADS; i++) begin : g_hit
    assign idx_hit[i] = (reg_idx == REG_IDX_W'(i));
  end

  assign idx_ok      = |idx_hit;
  assign reg_error_o = reg_valid_i && !idx_ok;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sel_q <= {NUM_MUX_PADS{PAD_SEL_PERIPH}};
    end else begin
      for (int i = 0; i < NUM_MUX_PADS; i++) begin
        if (reg_valid_i && reg_write_i && idx_hit[i]) begin
          sel_q[i] <= reg_wdata_i[REG_SEL_BIT];
        end
      end
    end
  end

  // Out-of-range reads fall through as zero
  always_comb begin
    reg_rdata_o = '0;
    for (int i = 0; i < NUM_MUX_PADS; i++) begin
      if (reg_valid_i && idx_hit[i]) begin
        reg_rdata_o[REG_SEL_BIT] = sel_q[i];
      end
    end
  end

  assign pad_sel_o = sel_q;

endmodule

// File: hw/pad_mux.sv
// ----------------------------------------------------------
// Shared pad multiplexer between peripheral and spare GPIO
// ----------------------------------------------------------

`timescale 1ns/1ps

module pad_mux
  import heep_io_pkg::*;
#(
  parameter int unsigned NUM_MUX_PADS = 14
) (
  input  logic [NUM_MUX_PADS-1:0] pad_sel_i,
  input  logic [NUM_MUX_PADS-1:0] periph_out_i,
  input  logic [NUM_MUX_PADS-1:0] periph_oe_i,
  input  logic [NUM_MUX_PADS-1:0] gpio_out_i,
  input  logic [NUM_MUX_PADS-1:0] gpio_oe_i,
  input  logic [NUM_MUX_PADS-1:0] pad_in_i,
  output logic [NUM_MUX_PADS-1:0] pad_out_o,
  output logic [NUM_MUX_PADS-1:0] pad_oe_o,
  output logic [NUM_MUX_PADS-1:0] periph_in_o,
  output logic [NUM_MUX_PADS-1:0] gpio_in_o
);

  for (genvar i = 0; i < NUM_MUX_PADS; i++) begin : g_pad
    logic to_gpio;

    assign to_gpio = (pad_sel_i[i] == PAD_SEL_GPIO);

    // Owner drives the pad
    assign pad_out_o[i] = to_gpio ? gpio_out_i[i] : periph_out_i[i];
    assign pad_oe_o[i]  = to_gpio ? gpio_oe_i[i]  : periph_oe_i[i];

    // Input seen only by the owner, the other side reads 0
    assign periph_in_o[i] = (pad_sel_i[i] == PAD_SEL_PERIPH) ? pad_in_i[i] : 1'b0;
    assign gpio_in_o[i]   = to_gpio ? pad_in_i[i] : 1'b0;
  end

endmodule

// File: hw/obi_xbar_n_to_one.sv
// ----------------------------------------------------------
// N-to-1 variable-latency OBI crossbar with round-robin
// arbitration and an in-order response queue
// ----------------------------------------------------------

`timescale 1ns/1ps

module obi_xbar_n_to_one
  import heep_io_pkg::*;
#(
  parameter int unsigned XBAR_NMASTER    = 5,
  parameter int unsigned MAX_OUTSTANDING = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic      [XBAR_NMASTER-1:0] mst_req_i,
  input  logic      [XBAR_NMASTER-1:0] mst_we_i,
  input  obi_addr_t [XBAR_NMASTER-1:0] mst_addr_i,
  input  obi_be_t   [XBAR_NMASTER-1:0] mst_be_i,
  input  obi_data_t [XBAR_NMASTER-1:0] mst_wdata_i,
  output logic      [XBAR_NMASTER-1:0] mst_gnt_o,
  output logic      [XBAR_NMASTER-1:0] mst_rvalid_o,
  output obi_data_t [XBAR_NMASTER-1:0] mst_rdata_o,
  output logic                         slv_req_o,
  output logic                         slv_we_o,
  output obi_addr_t                    slv_addr_o,
  output obi_be_t                      slv_be_o,
  output obi_data_t                    slv_wdata_o,
  input  logic                         slv_gnt_i,
  input  logic                         slv_rvalid_i,
  input  obi_data_t                    slv_rdata_i
);

  localparam int unsigned IDX_W = (XBAR_NMASTER > 1) ? $clog2(XBAR_NMASTER) : 1;
  localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
  localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic [IDX_W-1:0] rr_ptr_q;
  logic [IDX_W-1:0] sel_idx;
  logic             sel_found;
  logic             slot_free;
  logic             accept;

  // Response-order queue of master indices
  logic [IDX_W-1:0] queue_q [MAX_OUTSTANDING];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             queue_empty;
  logic [IDX_W-1:0] head_idx;
  logic             resp_valid;

  // First requester at or after the priority pointer
  always_comb begin
    int unsigned cand;
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int unsigned i = 0; i < XBAR_NMASTER; i++) begin
      cand = (int'(rr_ptr_q) + i) % XBAR_NMASTER;
      if (!sel_found && mst_req_i[cand]) begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(cand);
      end
    end
  end

  assign queue_empty = (cnt_q == '0);
  assign head_idx    = queue_q[rd_ptr_q];
  assign resp_valid  = slv_rvalid_i && !queue_empty;

  // A response this cycle frees its slot right away
  assign slot_free = (cnt_q < CNT_W'(MAX_OUTSTANDING)) || resp_valid;

  assign slv_req_o   = rst_n_i && sel_found && slot_free;
  assign slv_we_o    = mst_we_i[sel_idx];
  assign slv_addr_o  = mst_addr_i[sel_idx];
  assign slv_be_o    = mst_be_i[sel_idx];
  assign slv_wdata_o = mst_wdata_i[sel_idx];
  assign accept      = slv_req_o && slv_gnt_i;

  always_comb begin
    mst_gnt_o          = '0;
    mst_gnt_o[sel_idx] = accept;
  end

  always_comb begin
    mst_rvalid_o           = '0;
    mst_rvalid_o[head_idx] = resp_valid;
  end

  // Read data goes to all, rvalid marks the owner
  assign mst_rdata_o = {XBAR_NMASTER{slv_rdata_i}};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (accept) begin
        rr_ptr_q <= (sel_idx == IDX_W'(XBAR_NMASTER - 1)) ? '0 : sel_idx + 1'b1;
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (resp_valid) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX_OUTSTANDING - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({accept, resp_valid})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      queue_q[wr_ptr_q] <= sel_idx;
    end
  end

endmodule

// File: hw/heep_io_top.sv
// ----------------------------------------------------------
// I/O wrapper top: reset sync, pad control, pad mux and
// the external-domain bus crossbar
// ----------------------------------------------------------

`timescale 1ns/1ps

module heep_io_top
  import heep_io_pkg::*;
#(
  parameter int unsigned NUM_MUX_PADS    = 14,
  parameter int unsigned XBAR_NMASTER    = 5,
  parameter int unsigned MAX_OUTSTANDING = 4,
  parameter int unsigned RST_SYNC_STAGES = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // Register port
  input  logic                         reg_valid_i,
  input  logic                         reg_write_i,
  input  reg_addr_t                    reg_addr_i,
  input  reg_data_t                    reg_wdata_i,
  output reg_data_t                    reg_rdata_o,
  output logic                         reg_error_o,
  // Shared pads
  input  logic      [NUM_MUX_PADS-1:0] periph_out_i,
  input  logic      [NUM_MUX_PADS-1:0] periph_oe_i,
  input  logic      [NUM_MUX_PADS-1:0] gpio_out_i,
  input  logic      [NUM_MUX_PADS-1:0] gpio_oe_i,
  input  logic      [NUM_MUX_PADS-1:0] pad_in_i,
  output logic      [NUM_MUX_PADS-1:0] pad_out_o,
  output logic      [NUM_MUX_PADS-1:0] pad_oe_o,
  output logic      [NUM_MUX_PADS-1:0] periph_in_o,
  output logic      [NUM_MUX_PADS-1:0] gpio_in_o,
  // Bus masters
  input  logic      [XBAR_NMASTER-1:0] mst_req_i,
  input  logic      [XBAR_NMASTER-1:0] mst_we_i,
  input  obi_addr_t [XBAR_NMASTER-1:0] mst_addr_i,
  input  obi_be_t   [XBAR_NMASTER-1:0] mst_be_i,
  input  obi_data_t [XBAR_NMASTER-1:0] mst_wdata_i,
  output logic      [XBAR_NMASTER-1:0] mst_gnt_o,
  output logic      [XBAR_NMASTER-1:0] mst_rvalid_o,
  output obi_data_t [XBAR_NMASTER-1:0] mst_rdata_o,
  // Bus slave
  output logic                         slv_req_o,
  output logic                         slv_we_o,
  output obi_addr_t                    slv_addr_o,
  output obi_be_t                      slv_be_o,
  output obi_data_t                    slv_wdata_o,
  input  logic                         slv_gnt_i,
  input  logic                         slv_rvalid_i,
  input  obi_data_t                    slv_rdata_i
);

  logic                    rst_sync_n;
  logic [NUM_MUX_PADS-1:0] pad_sel;

  rst_sync #(
    .RST_SYNC_STAGES(RST_SYNC_STAGES)
  ) u_rst_sync (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rst_sync_n_o(rst_sync_n)
  );

  pad_ctrl_regs #(
    .NUM_MUX_PADS(NUM_MUX_PADS)
  ) u_pad_ctrl_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_sync_n),
    .reg_valid_i(reg_valid_i),
    .reg_write_i(reg_write_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .reg_error_o(reg_error_o),
    .pad_sel_o  (pad_sel)
  );

  pad_mux #(
    .NUM_MUX_PADS(NUM_MUX_PADS)
  ) u_pad_mux (
    .pad_sel_i   (pad_sel),
    .periph_out_i(periph_out_i),
    .periph_oe_i (periph_oe_i),
    .gpio_out_i  (gpio_out_i),
    .gpio_oe_i   (gpio_oe_i),
    .pad_in_i    (pad_in_i),
    .pad_out_o   (pad_out_o),
    .pad_oe_o    (pad_oe_o),
    .periph_in_o (periph_in_o),
    .gpio_in_o   (gpio_in_o)
  );

  // Master 0 core data, 1 debug, 2 to 4 DMA ports
  obi_xbar_n_to_one #(
    .XBAR_NMASTER   (XBAR_NMASTER),
    .MAX_OUTSTANDING(MAX_OUTSTANDING)
  ) u_xbar (
    .clk_i       (clk_i),
    .rst_n_i     (rst_sync_n),
    .mst_req_i   (mst_req_i),
    .mst_we_i    (mst_we_i),
    .mst_addr_i  (mst_addr_i),
    .mst_be_i    (mst_be_i),
    .mst_wdata_i (mst_wdata_i),
    .mst_gnt_o   (mst_gnt_o),
    .mst_rvalid_o(mst_rvalid_o),
    .mst_rdata_o (mst_rdata_o),
    .slv_req_o   (slv_req_o),
    .slv_we_o    (slv_we_o),
    .slv_addr_o  (slv_addr_o),
    .slv_be_o    (slv_be_o),
    .slv_wdata_o (slv_wdata_o),
    .slv_gnt_i   (slv_gnt_i),
    .slv_rvalid_i(slv_rvalid_i),
    .slv_rdata_i (slv_rdata_i)
  );

endmodule

// File: sim/tb_clk_gen.sv
// ----------------------------------------------------------
// Free-running testbench clock
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;
  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: sim/heep_io_props.sv
// ----------------------------------------------------------
// Crossbar grant and response routing properties
// ----------------------------------------------------------

`timescale 1ns/1ps

module heep_io_props #(
  parameter int unsigned XBAR_NMASTER = 5
) (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic [XBAR_NMASTER-1:0] mst_req_i,
  input logic [XBAR_NMASTER-1:0] mst_gnt_o,
  input logic [XBAR_NMASTER-1:0] mst_rvalid_o,
  input logic                    slv_gnt_i
);

  // Transfers granted but not yet answered, seen from the master side
  logic [7:0] open_cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      open_cnt_q <= '0;
    end else begin
      open_cnt_q <= open_cnt_q + 8'(|mst_gnt_o) - 8'(|mst_rvalid_o);
    end
  end

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(mst_gnt_o)) else $error("more than one master granted");

  // Grant needs the master's request and the slave's grant
  a_gnt_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mst_gnt_o & ~(mst_req_i & {XBAR_NMASTER{slv_gnt_i}})) == '0)
    else $error("grant without request or slave grant");

  a_rvalid_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(mst_rvalid_o)) else $error("rvalid routed to several masters");

  a_no_resp_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (open_cnt_q == '0) |-> (mst_rvalid_o == '0))
    else $error("response routed with no transfer outstanding");

endmodule

bind obi_xbar_n_to_one heep_io_props #(.XBAR_NMASTER(XBAR_NMASTER)) u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .mst_req_i   (mst_req_i),
  .mst_gnt_o   (mst_gnt_o),
  .mst_rvalid_o(mst_rvalid_o),
  .slv_gnt_i   (slv_gnt_i)
);

// File: sim/tb_heep_io_top.sv
// ----------------------------------------------------------
// Testbench for the I/O wrapper covering registers, pad mux
// and crossbar against a slave memory model
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_heep_io_top;
  import heep_io_pkg::*;

  localparam int NP = 14;
  localparam int NM = 5;
  localparam int MO = 4;
  localparam int SAMPLE = 15;
  localparam int TMO = 3000;

  logic clk_i;
  logic rst_n_i = 1'b0;
  logic reg_valid_i = 1'b0;
  logic reg_write_i = 1'b0;
  reg_addr_t reg_addr_i = '0;
  reg_data_t reg_wdata_i = '0;
  reg_data_t reg_rdata_o;
  logic reg_error_o;
  logic [NP-1:0] periph_out_i = '0;
  logic [NP-1:0] periph_oe_i = '0;
  logic [NP-1:0] gpio_out_i = '0;
  logic [NP-1:0] gpio_oe_i = '0;
  logic [NP-1:0] pad_in_i = '0;
  logic [NP-1:0] pad_out_o, pad_oe_o, periph_in_o, gpio_in_o;
  logic [NM-1:0] mst_req_i = '0;
  logic [NM-1:0] mst_we_i = '0;
  obi_addr_t [NM-1:0] mst_addr_i = '0;
  obi_be_t [NM-1:0] mst_be_i = '0;
  obi_data_t [NM-1:0] mst_wdata_i = '0;
  logic [NM-1:0] mst_gnt_o, mst_rvalid_o;
  obi_data_t [NM-1:0] mst_rdata_o;
  logic slv_req_o, slv_we_o;
  obi_addr_t slv_addr_o;
  obi_be_t slv_be_o;
  obi_data_t slv_wdata_o;
  logic slv_gnt_i = 1'b0;
  logic slv_rvalid_i = 1'b0;
  obi_data_t slv_rdata_i = '0;

  int n_checks = 0;
  int n_errors = 0;
  logic [31:0] rng = 32'h3842;
  logic [31:0] slv_rng = 32'h3842 ^ 32'h0001_0000;
  logic [NP-1:0] shadow = '0;
  // Slave model state
  obi_data_t mem [obi_addr_t];
  obi_addr_t pq_addr [$];
  logic pq_we [$];
  int head_wait = 0;
  int acc_count = 0;
  int resp_count = 0;
  bit gnt_always = 1'b0;
  bit hold_resp = 1'b0;
  // Master side expectations in issue order
  int exp_owner [$];
  bit exp_isrd [$];
  obi_data_t exp_val [$];
  int nxt [NM];
  bit granted [NM];
  obi_data_t cur_exp [NM];
  obi_data_t wdat [NM][16];
  int nw_ops, nr_ops, rr_next;
  bit rr_check = 1'b0;

  tb_clk_gen #(.PERIOD(40)) u_clk (.clk_o(clk_i));

  heep_io_top #(
    .NUM_MUX_PADS(NP), .XBAR_NMASTER(NM), .MAX_OUTSTANDING(MO), .RST_SYNC_STAGES(2)
  ) u_dut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic obi_data_t init_word(input obi_addr_t a);
    return a ^ 32'h5A5A_0000;
  endfunction

  function automatic obi_data_t mem_read(input obi_addr_t a);
    return mem.exists(a) ? mem[a] : init_word(a);
  endfunction

  function automatic obi_addr_t op_addr(input int m, input int k);
    return 32'h0000_1000 + 32'(m) * 32'h100 + 32'(k) * 4;
  endfunction

  // Packed as pad_out, pad_oe, periph_in, gpio_in
  function automatic logic [4*NP-1:0] pad_ref(input logic [NP-1:0] sel);
    logic [NP-1:0] po, oe, pi, gi;
    for (int i = 0; i < NP; i++) begin
      po[i] = sel[i] ? gpio_out_i[i] : periph_out_i[i];
      oe[i] = sel[i] ? gpio_oe_i[i] : periph_oe_i[i];
      pi[i] = sel[i] ? 1'b0 : pad_in_i[i];
      gi[i] = sel[i] ? pad_in_i[i] : 1'b0;
    end
    return {po, oe, pi, gi};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic check_pads();
    logic [4*NP-1:0] r;
    r = pad_ref(shadow);
    compare("pad_out_o", 32'(pad_out_o), 32'(r[4*NP-1:3*NP]));
    compare("pad_oe_o", 32'(pad_oe_o), 32'(r[3*NP-1:2*NP]));
    compare("periph_in_o", 32'(periph_in_o), 32'(r[2*NP-1:NP]));
    compare("gpio_in_o", 32'(gpio_in_o), 32'(r[NP-1:0]));
  endtask

  task automatic randomize_pads();
    periph_out_i = NP'(rand32());
    periph_oe_i = NP'(rand32());
    gpio_out_i = NP'(rand32());
    gpio_oe_i = NP'(rand32());
    pad_in_i = NP'(rand32());
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_n_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (3) @(negedge clk_i);
    shadow = '0;
  endtask

  task automatic reg_access(input bit wr, input reg_addr_t a, input reg_data_t wd,
                            output reg_data_t rd, output logic err);
    @(negedge clk_i);
    reg_valid_i = 1'b1;
    reg_write_i = wr;
    reg_addr_i = a;
    reg_wdata_i = wd;
    #SAMPLE;
    rd = reg_rdata_o;
    err = reg_error_o;
    @(negedge clk_i);
    reg_valid_i = 1'b0;
  endtask

  // Slave model drives on the falling edge and observes before the rising edge
  always @(negedge clk_i) begin
    slv_rvalid_i = 1'b0;
    slv_rdata_i = '0;
    if (pq_addr.size() > 0 && !hold_resp) begin
      if (head_wait == 0) begin
        slv_rvalid_i = 1'b1;
        slv_rdata_i = pq_we[0] ? '0 : mem_read(pq_addr[0]);
      end else begin
        head_wait--;
      end
    end
    slv_rng = xorshift(slv_rng);
    slv_gnt_i = gnt_always | slv_rng[0] | slv_rng[1];
    #SAMPLE;
    if (slv_rvalid_i) begin
      void'(pq_addr.pop_front());
      void'(pq_we.pop_front());
      head_wait = int'(slv_rng[9:8]);
      resp_count++;
      if (exp_owner.size() == 0) begin
        n_errors++;
        $display("Slave response at %0t with no transfer issued by a master", $time);
      end else begin
        automatic int own = exp_owner.pop_front();
        automatic bit isrd = exp_isrd.pop_front();
        automatic obi_data_t val = exp_val.pop_front();
        compare("mst_rvalid_o", 32'(mst_rvalid_o), 32'(1) << own);
        if (isrd) compare("mst_rdata_o", mst_rdata_o[own], val);
      end
    end else begin
      compare("mst_rvalid_o", 32'(mst_rvalid_o), 32'h0);
    end
    if (slv_req_o && slv_gnt_i) begin
      if (pq_addr.size() == 0) head_wait = int'(slv_rng[5:4]);
      pq_addr.push_back(slv_addr_o);
      pq_we.push_back(slv_we_o);
      if (slv_we_o) mem[slv_addr_o] = slv_wdata_o;
      acc_count++;
    end
  end

  task automatic start_ops(input int nw, input int nr);
    nw_ops = nw;
    nr_ops = nr;
    for (int m = 0; m < NM; m++) begin
      nxt[m] = 0;
      granted[m] = 1'b0;
    end
  endtask

  task automatic bus_cycle();
    int k;
    @(negedge clk_i);
    for (int m = 0; m < NM; m++) begin
      if (granted[m]) begin
        mst_req_i[m] = 1'b0;
        granted[m] = 1'b0;
      end
      if (!mst_req_i[m] && nxt[m] < nw_ops + nr_ops) begin
        k = nxt[m];
        mst_req_i[m] = 1'b1;
        mst_we_i[m] = (k < nw_ops);
        if (k < nw_ops) begin
          mst_addr_i[m] = op_addr(m, k);
          mst_be_i[m] = 4'hF;
          mst_wdata_i[m] = rand32();
          wdat[m][k] = mst_wdata_i[m];
          cur_exp[m] = '0;
        end else begin
          k = k - nw_ops;
          mst_addr_i[m] = op_addr(m, k);
          mst_be_i[m] = obi_be_t'(rand32());
          cur_exp[m] = (k < nw_ops) ? wdat[m][k] : init_word(op_addr(m, k));
        end
        nxt[m]++;
      end
    end
    #SAMPLE;
    for (int m = 0; m < NM; m++) begin
      if (mst_gnt_o[m]) begin
        compare("slv_addr_o", slv_addr_o, mst_addr_i[m]);
        compare("slv_we_o", 32'(slv_we_o), 32'(mst_we_i[m]));
        compare("slv_be_o", 32'(slv_be_o), 32'(mst_be_i[m]));
        if (mst_we_i[m]) compare("slv_wdata_o", slv_wdata_o, mst_wdata_i[m]);
        if (rr_check) begin
          compare("grant_index", 32'(m), 32'(rr_next));
          rr_next = (rr_next + 1) % NM;
        end
        exp_owner.push_back(m);
        exp_isrd.push_back(!mst_we_i[m]);
        exp_val.push_back(cur_exp[m]);
        granted[m] = 1'b1;
      end
    end
  endtask

  task automatic drain_bus(input string what);
    int t;
    bit busy;
    for (t = 0; t < TMO; t++) begin
      busy = (exp_owner.size() != 0) || (pq_addr.size() != 0);
      for (int m = 0; m < NM; m++) begin
        busy = busy || (nxt[m] < nw_ops + nr_ops) || (mst_req_i[m] && !granted[m]);
      end
      if (!busy) break;
      bus_cycle();
    end
    if (t == TMO) timeout_fail(what);
    @(negedge clk_i);
    mst_req_i = '0;
  endtask

  initial begin
    reg_data_t rd;
    logic err;
    int idx;
    int t;
    int acc0;
    int resp0;
    reg_data_t wd;
    apply_reset();

    // Reset state
    for (int i = 0; i < NP; i++) begin
      reg_access(1'b0, reg_addr_t'(i * 4), '0, rd, err);
      compare("reg_rdata_o", rd, '0);
      compare("reg_error_o", 32'(err), 0);
    end
    randomize_pads();
    #1 check_pads();

    // Register writes, read-back and out-of-range accesses
    for (int n = 0; n < 40; n++) begin
      idx = int'(rand32() % 24);
      wd = rand32();
      reg_access(1'b1, reg_addr_t'(idx * 4 + (n % 4)), wd, rd, err);
      compare("reg_error_o", 32'(err), 32'(idx >= NP));
      if (idx < NP) shadow[idx] = wd[0];
      reg_access(1'b0, reg_addr_t'(idx * 4), '0, rd, err);
      compare("reg_rdata_o", rd, (idx < NP) ? 32'(shadow[idx]) : 32'h0);
      compare("reg_error_o", 32'(err), 32'(idx >= NP));
    end
    for (int i = 0; i < NP; i++) begin
      reg_access(1'b0, reg_addr_t'(i * 4), '0, rd, err);
      compare("reg_rdata_o", rd, 32'(shadow[i]));
    end

    // Pad mux with selects changing under random inputs
    for (int n = 0; n < 60; n++) begin
      @(negedge clk_i);
      randomize_pads();
      idx = int'(rand32() % NP);
      wd = rand32();
      reg_valid_i = (n % 3 == 0);
      reg_write_i = 1'b1;
      reg_addr_i = reg_addr_t'(idx * 4);
      reg_wdata_i = wd;
      #SAMPLE;
      check_pads();
      if (reg_valid_i) shadow[idx] = wd[0];
    end
    @(negedge clk_i);
    reg_valid_i = 1'b0;

    // Writes then reads from every master with a random slave
    start_ops(6, 7);
    drain_bus("read/write traffic to finish");

    // Outstanding limit with responses held back
    gnt_always = 1'b1;
    hold_resp = 1'b1;
    acc0 = acc_count;
    start_ops(6, 0);
    repeat (12) bus_cycle();
    compare("accepted_while_held", 32'(acc_count - acc0), 32'(MO));
    compare("slv_req_o", 32'(slv_req_o), 0);
    hold_resp = 1'b0;
    acc0 = acc_count;
    resp0 = resp_count;
    for (t = 0; t < TMO && acc_count == acc0; t++) begin
      bus_cycle();
      #1;
    end
    if (t == TMO) begin
      timeout_fail("issue to resume after a response");
    end else begin
      // The first response frees its slot in its own cycle
      compare("responses_before_resume", 32'(resp_count - resp0), 32'd1);
    end
    drain_bus("held traffic to finish");

    // Round-robin order from a fresh reset
    apply_reset();
    rr_next = 0;
    rr_check = 1'b1;
    start_ops(8, 0);
    drain_bus("round-robin traffic to finish");
    rr_check = 1'b0;

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: heep_io_top.f
hw/heep_io_pkg.sv
hw/rst_sync.sv
hw/pad_ctrl_regs.sv
hw/pad_mux.sv
hw/obi_xbar_n_to_one.sv
hw/heep_io_top.sv
sim/tb_clk_gen.sv
sim/heep_io_props.sv
sim/tb_heep_io_top.sv

// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_heep_io_top
RTL_TOP  ?= heep_io_top
FILELIST ?= heep_io_top.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
FAIL_MSG := Test failures found
PASS_MSG := All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
